//--- rtl/exu_pkg.sv
package exu_pkg;

  // ------------------------------------------------------------
  // Major opcodes.
  // ------------------------------------------------------------
  localparam logic [6:0] OP_R_TYPE  = 7'b0110011;
  localparam logic [6:0] OP_I_TYPE  = 7'b0010011;
  localparam logic [6:0] OP_IL_TYPE = 7'b0000011;
  localparam logic [6:0] OP_S_TYPE  = 7'b0100011;
  localparam logic [6:0] OP_B_TYPE  = 7'b1100011;
  localparam logic [6:0] OP_JAL     = 7'b1101111;
  localparam logic [6:0] OP_JALR    = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

  // ------------------------------------------------------------
  // ALU operations.
  // ------------------------------------------------------------
  localparam logic [3:0] ALU_OP_ADD  = 4'd0;
  localparam logic [3:0] ALU_OP_SUB  = 4'd1;
  localparam logic [3:0] ALU_OP_AND  = 4'd2;
  localparam logic [3:0] ALU_OP_OR   = 4'd3;
  localparam logic [3:0] ALU_OP_XOR  = 4'd4;
  localparam logic [3:0] ALU_OP_SLL  = 4'd5;
  localparam logic [3:0] ALU_OP_SRL  = 4'd6;
  localparam logic [3:0] ALU_OP_SRA  = 4'd7;
  localparam logic [3:0] ALU_OP_SLT  = 4'd8;
  localparam logic [3:0] ALU_OP_SLTU = 4'd9;
  localparam logic [3:0] ALU_OP_SLE  = 4'd10;
  localparam logic [3:0] ALU_OP_SLEU = 4'd11;

  // System function, carried in imm[3:0].
  localparam logic [3:0] SYS_FUNC3_PRIV = 4'd0;
  localparam logic [3:0] SYS_CSRRW      = 4'd1;
  localparam logic [3:0] SYS_CSRRS      = 4'd2;
  localparam logic [3:0] SYS_CSRRC      = 4'd3;
  localparam logic [3:0] SYS_CSRRWI     = 4'd5;
  localparam logic [3:0] SYS_CSRRSI     = 4'd6;
  localparam logic [3:0] SYS_CSRRCI     = 4'd7;

  // Privileged function, carried in imm[15:4].
  localparam logic [11:0] SYS_ECALL  = 12'h000;
  localparam logic [11:0] SYS_EBREAK = 12'h001;
  localparam logic [11:0] SYS_MRET   = 12'h302;

  // Machine-mode CSR addresses.
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam logic [31:0] CAUSE_ECALL_M = 32'd11;

endpackage

//--- rtl/exu_alu.sv
`timescale 1ns/1ns

module exu_alu #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic [3:0]      alu_op_i,
  output logic [XLEN-1:0] res_o
);

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_s;
  logic           lt_u;
  logic           eq;

  assign shamt = src2_i[SHW-1:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  always_comb begin
    case (alu_op_i)
      exu_pkg::ALU_OP_ADD:  res_o = src1_i + src2_i;
      exu_pkg::ALU_OP_SUB:  res_o = src1_i - src2_i;
      exu_pkg::ALU_OP_AND:  res_o = src1_i & src2_i;
      exu_pkg::ALU_OP_OR:   res_o = src1_i | src2_i;
      exu_pkg::ALU_OP_XOR:  res_o = src1_i ^ src2_i;
      exu_pkg::ALU_OP_SLL:  res_o = src1_i << shamt;
      exu_pkg::ALU_OP_SRL:  res_o = src1_i >> shamt;
      exu_pkg::ALU_OP_SRA:  res_o = $unsigned($signed(src1_i) >>> shamt);
      // Comparisons give 0 or 1.
      exu_pkg::ALU_OP_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      exu_pkg::ALU_OP_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      exu_pkg::ALU_OP_SLE:  res_o = {{(XLEN-1){1'b0}}, lt_s | eq};
      exu_pkg::ALU_OP_SLEU: res_o = {{(XLEN-1){1'b0}}, lt_u | eq};
      default:              res_o = '0;
    endcase
  end

endmodule

//--- rtl/exu_csr_file.sv
`timescale 1ns/1ns

module exu_csr_file #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            wen_i,
  input  logic            commit_i,
  input  logic [11:0]     waddr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic            ecall_en_i,
  input  logic [XLEN-1:0] epc_i,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] mepc_o,
  output logic [XLEN-1:0] mtvec_o
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  // Updates land only on the edge that retires the instruction.
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (commit_i) begin
      if (wen_i) begin
        case (waddr_i)
          exu_pkg::CSR_MSTATUS: mstatus <= wdata_i;
          exu_pkg::CSR_MTVEC:   mtvec   <= wdata_i;
          exu_pkg::CSR_MEPC:    mepc    <= wdata_i;
          exu_pkg::CSR_MCAUSE:  mcause  <= wdata_i;
          default: ;
        endcase
      end
      // Second port, ECALL saves its pc.
      if (ecall_en_i) begin
        mepc <= epc_i;
      end
    end
  end

  always_comb begin
    case (waddr_i)
      exu_pkg::CSR_MSTATUS: rdata_o = mstatus;
      exu_pkg::CSR_MTVEC:   rdata_o = mtvec;
      exu_pkg::CSR_MEPC:    rdata_o = mepc;
      exu_pkg::CSR_MCAUSE:  rdata_o = mcause;
      default:              rdata_o = '0;
    endcase
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

endmodule

//--- rtl/exu_stage.sv
`timescale 1ns/1ns

module exu_stage #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  // Handshake.
  input  logic            prev_valid_i,
  input  logic            next_ready_i,
  output logic            ready_o,
  output logic            valid_o,
  // Decoded instruction.
  input  logic            ren_i,
  input  logic            wen_i,
  input  logic            rwen_i,
  input  logic [4:0]      rd_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] op_j_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [3:0]      alu_op_i,
  input  logic [6:0]      opcode_i,
  // Data memory.
  output logic            lsu_avalid_o,
  output logic            lsu_wen_o,
  output logic [XLEN-1:0] lsu_addr_o,
  output logic [XLEN-1:0] lsu_wdata_o,
  input  logic [XLEN-1:0] lsu_rdata_i,
  input  logic            lsu_rvalid_i,
  input  logic            lsu_wready_i,
  // Results.
  output logic [XLEN-1:0] reg_wdata_o,
  output logic [XLEN-1:0] npc_o,
  output logic [4:0]      rd_o,
  output logic            rwen_o,
  output logic            wben_o,
  output logic            ebreak_o
);

  logic            busy_q;
  logic            valid_q;
  logic            avalid_q;
  logic            accept;
  logic            commit;
  logic            mem_done;

  logic [XLEN-1:0] imm_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] src1_q;
  logic [XLEN-1:0] src2_q;
  logic [XLEN-1:0] target_q;
  logic [XLEN-1:0] mem_rdata_q;
  logic [3:0]      alu_op_q;
  logic [6:0]      opcode_q;
  logic [4:0]      rd_q;
  logic            rwen_q;
  logic            wen_q;

  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] pc_plus4;
  logic            branch_taken;

  logic            is_system;
  logic            is_priv;
  logic            is_ecall;
  logic            is_mret;
  logic [3:0]      sys_func;
  logic            csr_wen;
  logic [11:0]     csr_waddr;
  logic [XLEN-1:0] csr_wdata;
  logic [XLEN-1:0] csr_rdata;
  logic            csr_ecall_en;
  logic [XLEN-1:0] csr_epc;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mtvec;

  // ------------------------------------------------------------
  // Handshake and memory request control.
  // ------------------------------------------------------------
  assign ready_o  = !busy_q;
  assign accept   = prev_valid_i && ready_o;
  assign commit   = valid_q && next_ready_i;
  assign mem_done = avalid_q && (lsu_rvalid_i || lsu_wready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      valid_q  <= 1'b0;
      avalid_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
      if (ren_i || wen_i) begin
        avalid_q <= 1'b1;
      end else begin
        valid_q <= 1'b1;
      end
    end else if (mem_done) begin
      avalid_q <= 1'b0;
      valid_q  <= 1'b1;
    end else if (commit) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
    end
  end

  // Operand latch.
  always_ff @(posedge clk) begin
    if (accept) begin
      imm_q    <= imm_i;
      pc_q     <= pc_i;
      src1_q   <= op1_i;
      src2_q   <= op2_i;
      target_q <= op_j_i + imm_i;
      alu_op_q <= alu_op_i;
      opcode_q <= opcode_i;
      rd_q     <= rd_i;
      rwen_q   <= rwen_i;
      wen_q    <= wen_i;
    end
    if (avalid_q && lsu_rvalid_i) begin
      mem_rdata_q <= lsu_rdata_i;
    end
  end

  assign valid_o      = valid_q;
  assign lsu_avalid_o = avalid_q;
  assign lsu_wen_o    = wen_q;
  assign lsu_addr_o   = target_q;
  assign lsu_wdata_o  = src2_q;

  exu_alu #(.XLEN(XLEN)) alu0 (
    .src1_i  (src1_q),
    .src2_i  (src2_q),
    .alu_op_i(alu_op_q),
    .res_o   (alu_res)
  );

  // ------------------------------------------------------------
  // Next PC and writeback.
  // ------------------------------------------------------------
  assign sys_func  = imm_q[3:0];
  assign is_system = opcode_q == exu_pkg::OP_SYSTEM;
  assign is_priv   = is_system && (sys_func == exu_pkg::SYS_FUNC3_PRIV);
  assign is_ecall  = is_priv && (imm_q[15:4] == exu_pkg::SYS_ECALL);
  assign is_mret   = is_priv && (imm_q[15:4] == exu_pkg::SYS_MRET);
  assign ebreak_o  = valid_q && is_priv && (imm_q[15:4] == exu_pkg::SYS_EBREAK);

  assign pc_plus4 = pc_q + XLEN'(4);
  // BEQ uses SUB, so taken on zero.
  assign branch_taken = (alu_op_q == exu_pkg::ALU_OP_SUB) ? ~|alu_res : |alu_res;

  always_comb begin
    npc_o = pc_plus4;
    case (opcode_q)
      exu_pkg::OP_SYSTEM: begin
        if (is_ecall) begin
          npc_o = mtvec;
        end else if (is_mret) begin
          npc_o = mepc;
        end
      end
      exu_pkg::OP_JAL, exu_pkg::OP_JALR: npc_o = target_q;
      exu_pkg::OP_B_TYPE: begin
        if (branch_taken) begin
          npc_o = target_q;
        end
      end
      default: ;
    endcase
  end

  assign reg_wdata_o = (opcode_q == exu_pkg::OP_IL_TYPE) ? mem_rdata_q :
                       is_system ? csr_rdata : alu_res;
  assign rd_o   = rd_q;
  assign rwen_o = rwen_q;
  assign wben_o = valid_q && rwen_q;

  // ------------------------------------------------------------
  // CSR access.
  // ------------------------------------------------------------
  assign csr_waddr = is_ecall ? exu_pkg::CSR_MCAUSE :
                     is_mret  ? exu_pkg::CSR_MSTATUS : imm_q[15:4];
  assign csr_ecall_en = is_ecall;
  assign csr_epc      = pc_q;

  always_comb begin
    csr_wen   = is_system;
    csr_wdata = '0;
    case (sys_func)
      exu_pkg::SYS_CSRRW, exu_pkg::SYS_CSRRWI: csr_wdata = src1_q;
      exu_pkg::SYS_CSRRS, exu_pkg::SYS_CSRRSI: csr_wdata = csr_rdata | src1_q;
      exu_pkg::SYS_CSRRC, exu_pkg::SYS_CSRRCI: csr_wdata = csr_rdata & ~src1_q;
      exu_pkg::SYS_FUNC3_PRIV: begin
        if (is_ecall) begin
          csr_wdata = XLEN'(exu_pkg::CAUSE_ECALL_M);
        end else if (is_mret) begin
          // MPIE takes the MIE bit.
          csr_wdata = {csr_rdata[XLEN-1:8], csr_rdata[3], csr_rdata[6:0]};
        end else begin
          csr_wen = 1'b0;
        end
      end
      default: csr_wen = 1'b0;
    endcase
  end

  exu_csr_file #(.XLEN(XLEN)) csr0 (
    .clk       (clk),
    .rst       (rst),
    .wen_i     (csr_wen),
    .commit_i  (commit),
    .waddr_i   (csr_waddr),
    .wdata_i   (csr_wdata),
    .ecall_en_i(csr_ecall_en),
    .epc_i     (csr_epc),
    .rdata_o   (csr_rdata),
    .mepc_o    (mepc),
    .mtvec_o   (mtvec)
  );

endmodule

//--- rtl/exu_data_mem.sv
`timescale 1ns/1ns

module exu_data_mem #(
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 256
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            avalid_i,
  input  logic            wen_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic [XLEN-1:0] rdata_o,
  output logic            rvalid_o,
  output logic            wready_o
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [AW-1:0]   widx;
  logic            busy_q;
  logic            serve;

  assign widx  = addr_i[AW+1:2];
  // One response per strobe, even if the strobe is held.
  assign serve = avalid_i && !busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
    end else begin
      busy_q   <= avalid_i;
      rvalid_o <= serve && !wen_i;
      wready_o <= serve && wen_i;
    end
  end

  always_ff @(posedge clk) begin
    if (serve) begin
      if (wen_i) begin
        mem[widx] <= wdata_i;
      end else begin
        rdata_o <= mem[widx];
      end
    end
  end

endmodule

//--- rtl/exu_top.sv
`timescale 1ns/1ns

module exu_top #(
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 256
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            prev_valid_i,
  input  logic            next_ready_i,
  output logic            ready_o,
  output logic            valid_o,
  input  logic            ren_i,
  input  logic            wen_i,
  input  logic            rwen_i,
  input  logic [4:0]      rd_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] op_j_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [3:0]      alu_op_i,
  input  logic [6:0]      opcode_i,
  output logic [XLEN-1:0] reg_wdata_o,
  output logic [XLEN-1:0] npc_o,
  output logic [4:0]      rd_o,
  output logic            rwen_o,
  output logic            wben_o,
  output logic            ebreak_o
);

  logic            lsu_avalid;
  logic            lsu_wen;
  logic [XLEN-1:0] lsu_addr;
  logic [XLEN-1:0] lsu_wdata;
  logic [XLEN-1:0] lsu_rdata;
  logic            lsu_rvalid;
  logic            lsu_wready;

  exu_stage #(.XLEN(XLEN)) stage0 (
    .clk         (clk),
    .rst         (rst),
    .prev_valid_i(prev_valid_i),
    .next_ready_i(next_ready_i),
    .ready_o     (ready_o),
    .valid_o     (valid_o),
    .ren_i       (ren_i),
    .wen_i       (wen_i),
    .rwen_i      (rwen_i),
    .rd_i        (rd_i),
    .imm_i       (imm_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .op_j_i      (op_j_i),
    .pc_i        (pc_i),
    .alu_op_i    (alu_op_i),
    .opcode_i    (opcode_i),
    .lsu_avalid_o(lsu_avalid),
    .lsu_wen_o   (lsu_wen),
    .lsu_addr_o  (lsu_addr),
    .lsu_wdata_o (lsu_wdata),
    .lsu_rdata_i (lsu_rdata),
    .lsu_rvalid_i(lsu_rvalid),
    .lsu_wready_i(lsu_wready),
    .reg_wdata_o (reg_wdata_o),
    .npc_o       (npc_o),
    .rd_o        (rd_o),
    .rwen_o      (rwen_o),
    .wben_o      (wben_o),
    .ebreak_o    (ebreak_o)
  );

  exu_data_mem #(
    .XLEN     (XLEN),
    .MEM_WORDS(MEM_WORDS)
  ) mem0 (
    .clk     (clk),
    .rst     (rst),
    .avalid_i(lsu_avalid),
    .wen_i   (lsu_wen),
    .addr_i  (lsu_addr),
    .wdata_i (lsu_wdata),
    .rdata_o (lsu_rdata),
    .rvalid_o(lsu_rvalid),
    .wready_o(lsu_wready)
  );

endmodule

//--- tests/tb_exu_top.sv
`timescale 1ns/1ns

module tb_exu_top;

  localparam int XLEN       = 32;
  localparam int MEM_WORDS  = 256;
  localparam int CLK_PERIOD = 40;
  localparam int MAX_WAIT   = 100;
  localparam int N_ALU      = 16;
  localparam int N_BP       = 16;
  // Directed instructions in the branch, memory, CSR and system groups.
  localparam int N_FIXED    = 41;
  localparam int WATCHDOG_CYCLES = (N_ALU + N_BP + N_FIXED) * 200;

  logic            clk;
  logic            rst;
  logic            prev_valid_i;
  logic            next_ready_i;
  logic            ready_o;
  logic            valid_o;
  logic            ren_i;
  logic            wen_i;
  logic            rwen_i;
  logic [4:0]      rd_i;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] op1_i;
  logic [XLEN-1:0] op2_i;
  logic [XLEN-1:0] op_j_i;
  logic [XLEN-1:0] pc_i;
  logic [3:0]      alu_op_i;
  logic [6:0]      opcode_i;
  logic [XLEN-1:0] reg_wdata_o;
  logic [XLEN-1:0] npc_o;
  logic [4:0]      rd_o;
  logic            rwen_o;
  logic            wben_o;
  logic            ebreak_o;

  // Reference model state.
  logic [31:0] m_mstatus;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] mem_model [MEM_WORDS];
  logic [31:0] exp_wdata;
  logic [31:0] exp_npc;
  logic [4:0]  exp_rd;
  logic        exp_wben;
  logic        exp_ebreak;

  logic [31:0] rng_state;
  logic        bp_en;
  int          mismatch_errs;
  int          proto_errs;
  logic [31:0] addr_list [4];
  logic [3:0]  br_ops [6] = '{exu_pkg::ALU_OP_SUB, exu_pkg::ALU_OP_XOR, exu_pkg::ALU_OP_SLT,
                              exu_pkg::ALU_OP_SLTU, exu_pkg::ALU_OP_SLE, exu_pkg::ALU_OP_SLEU};

  exu_top #(
    .XLEN     (XLEN),
    .MEM_WORDS(MEM_WORDS)
  ) dut0 (
    .clk         (clk),
    .rst         (rst),
    .prev_valid_i(prev_valid_i),
    .next_ready_i(next_ready_i),
    .ready_o     (ready_o),
    .valid_o     (valid_o),
    .ren_i       (ren_i),
    .wen_i       (wen_i),
    .rwen_i      (rwen_i),
    .rd_i        (rd_i),
    .imm_i       (imm_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .op_j_i      (op_j_i),
    .pc_i        (pc_i),
    .alu_op_i    (alu_op_i),
    .opcode_i    (opcode_i),
    .reg_wdata_o (reg_wdata_o),
    .npc_o       (npc_o),
    .rd_o        (rd_o),
    .rwen_o      (rwen_o),
    .wben_o      (wben_o),
    .ebreak_o    (ebreak_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // Helpers and reference model.
  // ------------------------------------------------------------
  function logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] rand_pc();
    logic [31:0] r;
    r = rand32();
    return {r[31:2], 2'b00};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [31:0] a, input logic [31:0] b,
                                          input logic [3:0] op);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (op)
      exu_pkg::ALU_OP_ADD:  return a + b;
      exu_pkg::ALU_OP_SUB:  return a - b;
      exu_pkg::ALU_OP_AND:  return a & b;
      exu_pkg::ALU_OP_OR:   return a | b;
      exu_pkg::ALU_OP_XOR:  return a ^ b;
      exu_pkg::ALU_OP_SLL:  return a << b[4:0];
      exu_pkg::ALU_OP_SRL:  return a >> b[4:0];
      exu_pkg::ALU_OP_SRA:  return sa >>> b[4:0];
      exu_pkg::ALU_OP_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
      exu_pkg::ALU_OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
      exu_pkg::ALU_OP_SLE:  return (sa <= sb) ? 32'd1 : 32'd0;
      exu_pkg::ALU_OP_SLEU: return (a <= b) ? 32'd1 : 32'd0;
      default:              return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] csr_read(input logic [11:0] addr);
    case (addr)
      exu_pkg::CSR_MSTATUS: return m_mstatus;
      exu_pkg::CSR_MTVEC:   return m_mtvec;
      exu_pkg::CSR_MEPC:    return m_mepc;
      exu_pkg::CSR_MCAUSE:  return m_mcause;
      default:              return 32'd0;
    endcase
  endfunction

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      exu_pkg::CSR_MSTATUS: m_mstatus = val;
      exu_pkg::CSR_MTVEC:   m_mtvec = val;
      exu_pkg::CSR_MEPC:    m_mepc = val;
      exu_pkg::CSR_MCAUSE:  m_mcause = val;
      default: ;
    endcase
  endtask

  // Sets the expected results and advances the model by one instruction.
  task automatic predict(input logic [6:0] opc, input logic [3:0] aop, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] opj,
                         input logic [31:0] imm, input logic [31:0] pc);
    logic [31:0] alu;
    logic [31:0] old;
    logic [31:0] target;
    int          idx;
    alu = alu_ref(a, b, aop);
    target = opj + imm;
    idx = (target >> 2) % MEM_WORDS;
    exp_wdata = alu;
    exp_npc = pc + 32'd4;
    exp_ebreak = 1'b0;
    case (opc)
      exu_pkg::OP_JAL, exu_pkg::OP_JALR: exp_npc = target;
      exu_pkg::OP_B_TYPE: begin
        if ((aop == exu_pkg::ALU_OP_SUB) ? (alu == 0) : (alu != 0)) begin
          exp_npc = target;
        end
      end
      exu_pkg::OP_S_TYPE:  mem_model[idx] = b;
      exu_pkg::OP_IL_TYPE: exp_wdata = mem_model[idx];
      exu_pkg::OP_SYSTEM: begin
        if (imm[3:0] == exu_pkg::SYS_FUNC3_PRIV) begin
          if (imm[15:4] == exu_pkg::SYS_ECALL) begin
            exp_wdata = m_mcause;
            exp_npc = m_mtvec;
            m_mepc = pc;
            m_mcause = exu_pkg::CAUSE_ECALL_M;
          end else if (imm[15:4] == exu_pkg::SYS_MRET) begin
            exp_wdata = m_mstatus;
            exp_npc = m_mepc;
            m_mstatus[7] = m_mstatus[3];
          end else begin
            exp_wdata = csr_read(imm[15:4]);
            exp_ebreak = (imm[15:4] == exu_pkg::SYS_EBREAK);
          end
        end else begin
          old = csr_read(imm[15:4]);
          exp_wdata = old;
          case (imm[3:0])
            exu_pkg::SYS_CSRRW, exu_pkg::SYS_CSRRWI: csr_write(imm[15:4], a);
            exu_pkg::SYS_CSRRS, exu_pkg::SYS_CSRRSI: csr_write(imm[15:4], old | a);
            exu_pkg::SYS_CSRRC, exu_pkg::SYS_CSRRCI: csr_write(imm[15:4], old & ~a);
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  endtask

  // ------------------------------------------------------------
  // Stimulus tasks. Each starts and ends on a falling edge.
  // ------------------------------------------------------------
  task automatic issue(input logic [6:0] opc, input logic [3:0] aop, input logic [31:0] a,
                       input logic [31:0] b, input logic [31:0] opj, input logic [31:0] imm,
                       input logic [31:0] pc, input logic rd_wr);
    logic [31:0] r;
    int          waited;
    logic        done;
    if (!ready_o) begin
      proto_errs++;
      $display("Stage not ready for a new instruction at %0t", $time);
    end
    r = rand32();
    opcode_i = opc;
    alu_op_i = aop;
    op1_i = a;
    op2_i = b;
    op_j_i = opj;
    imm_i = imm;
    pc_i = pc;
    rd_i = r[4:0];
    rwen_i = rd_wr;
    ren_i = (opc == exu_pkg::OP_IL_TYPE);
    wen_i = (opc == exu_pkg::OP_S_TYPE);
    prev_valid_i = 1'b1;
    next_ready_i = 1'b0;
    exp_rd = r[4:0];
    exp_wben = rd_wr;
    predict(opc, aop, a, b, opj, imm, pc);
    @(negedge clk);
    prev_valid_i = 1'b0;
    done = 1'b0;
    waited = 0;
    while (!done && waited < MAX_WAIT) begin
      r = rand32();
      next_ready_i = bp_en ? r[16] : 1'b1;
      done = valid_o && next_ready_i;
      waited++;
      @(negedge clk);
    end
    next_ready_i = 1'b0;
    if (!done) begin
      proto_errs++;
      $display("No result from the stage within %0d cycles at %0t", MAX_WAIT, $time);
    end
  endtask

  task automatic random_alu();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    r = rand32();
    a = rand32();
    b = rand32();
    if (r[8]) begin
      if (r[12:10] == 3'd0) begin
        b = a;
      end
      issue(exu_pkg::OP_R_TYPE, 4'(r % 12), a, b, 32'd0, 32'd0, rand_pc(), 1'b1);
    end else begin
      b = sext12(b[11:0]);
      issue(exu_pkg::OP_I_TYPE, 4'(r % 12), a, b, 32'd0, b, rand_pc(), 1'b1);
    end
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
    issue(exu_pkg::OP_S_TYPE, exu_pkg::ALU_OP_ADD, addr - 32'd16, data, addr - 32'd16,
          32'd16, rand_pc(), 1'b0);
  endtask

  task automatic load_word(input logic [31:0] addr);
    issue(exu_pkg::OP_IL_TYPE, exu_pkg::ALU_OP_ADD, addr + 32'd8, 32'd0, addr + 32'd8,
          32'hffff_fff8, rand_pc(), 1'b1);
  endtask

  task automatic csr_op(input logic [3:0] func, input logic [11:0] addr, input logic [31:0] src);
    issue(exu_pkg::OP_SYSTEM, exu_pkg::ALU_OP_ADD, src, 32'd0, 32'd0, {16'h0, addr, func},
          rand_pc(), 1'b1);
  endtask

  task automatic sys_op(input logic [11:0] code);
    issue(exu_pkg::OP_SYSTEM, exu_pkg::ALU_OP_ADD, 32'd0, 32'd0, 32'd0,
          {16'h0, code, exu_pkg::SYS_FUNC3_PRIV}, rand_pc(), 1'b0);
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    mismatch_errs++;
    $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
  endtask

  task automatic print_counts();
    $display("Error counts: %0d mismatches, %0d handshake failures", mismatch_errs, proto_errs);
  endtask

  // ------------------------------------------------------------
  // Checks on every cycle that holds a result.
  // ------------------------------------------------------------
  assert property (@(posedge clk) disable iff (rst) valid_o |-> reg_wdata_o == exp_wdata)
    else report_mismatch("reg_wdata_o", $sampled(reg_wdata_o), exp_wdata);
  assert property (@(posedge clk) disable iff (rst) valid_o |-> npc_o == exp_npc)
    else report_mismatch("npc_o", $sampled(npc_o), exp_npc);
  assert property (@(posedge clk) disable iff (rst) valid_o |-> rd_o == exp_rd)
    else report_mismatch("rd_o", 32'($sampled(rd_o)), 32'(exp_rd));
  assert property (@(posedge clk) disable iff (rst) valid_o |-> rwen_o == exp_wben)
    else report_mismatch("rwen_o", 32'($sampled(rwen_o)), 32'(exp_wben));
  assert property (@(posedge clk) disable iff (rst) valid_o |-> wben_o == exp_wben)
    else report_mismatch("wben_o", 32'($sampled(wben_o)), 32'(exp_wben));
  assert property (@(posedge clk) disable iff (rst) valid_o |-> ebreak_o == exp_ebreak)
    else report_mismatch("ebreak_o", 32'($sampled(ebreak_o)), 32'(exp_ebreak));
  assert property (@(posedge clk) disable iff (rst) valid_o |-> !ready_o)
    else report_mismatch("ready_o with a result held", 32'd1, 32'd0);
  // Stalled results stay put.
  assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |=> valid_o && !ready_o && $stable(reg_wdata_o) && $stable(npc_o))
    else report_mismatch("result under back-pressure", $sampled(reg_wdata_o), exp_wdata);

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    print_counts();
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [31:0] a;
    logic [31:0] pc;
    logic [31:0] r;
    clk = 1'b0;
    rst = 1'b1;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    ren_i = 1'b0;
    wen_i = 1'b0;
    rwen_i = 1'b0;
    rd_i = '0;
    imm_i = '0;
    op1_i = '0;
    op2_i = '0;
    op_j_i = '0;
    pc_i = '0;
    alu_op_i = '0;
    opcode_i = '0;
    m_mstatus = '0;
    m_mtvec = '0;
    m_mepc = '0;
    m_mcause = '0;
    exp_wdata = '0;
    exp_npc = '0;
    exp_rd = '0;
    exp_wben = 1'b0;
    exp_ebreak = 1'b0;
    rng_state = 32'hed35_0262;
    bp_en = 1'b0;
    mismatch_errs = 0;
    proto_errs = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (!valid_o && ready_o && !ebreak_o && !wben_o)
      else begin
        mismatch_errs++;
        $display("MISMATCH at %0t: after reset valid_o=%b ready_o=%b ebreak_o=%b wben_o=%b",
                 $time, valid_o, ready_o, ebreak_o, wben_o);
      end

    for (int i = 0; i < N_ALU; i++) begin
      random_alu();
    end

    // Every compare kind runs once with equal and once with random operands.
    for (int k = 0; k < 6; k++) begin
      for (int m = 0; m < 2; m++) begin
        a = rand32();
        pc = rand_pc();
        r = rand32();
        issue(exu_pkg::OP_B_TYPE, br_ops[k], a, (m == 0) ? a : rand32(), pc,
              sext12({r[11:1], 1'b0}), pc, 1'b0);
      end
    end
    pc = rand_pc();
    r = rand32();
    issue(exu_pkg::OP_JAL, exu_pkg::ALU_OP_ADD, pc, 32'd4, pc, {{11{r[20]}}, r[20:1], 1'b0},
          pc, 1'b1);
    pc = rand_pc();
    issue(exu_pkg::OP_JALR, exu_pkg::ALU_OP_ADD, pc, 32'd4, rand32(), sext12(r[11:0]), pc, 1'b1);

    for (int j = 0; j < 4; j++) begin
      r = rand32();
      addr_list[j] = {22'h0, r[9:2], 2'b00};
      store_word(addr_list[j], rand32());
    end
    for (int j = 3; j >= 0; j--) begin
      load_word(addr_list[j]);
    end
    store_word(addr_list[1], rand32());
    load_word(addr_list[1]);
    load_word(addr_list[2]);
    load_word(addr_list[0]);

    csr_op(exu_pkg::SYS_CSRRW, exu_pkg::CSR_MTVEC, rand32());
    csr_op(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MTVEC, rand32());
    csr_op(exu_pkg::SYS_CSRRC, exu_pkg::CSR_MTVEC, rand32());
    csr_op(exu_pkg::SYS_CSRRWI, exu_pkg::CSR_MTVEC, 32'h0000_0015);
    csr_op(exu_pkg::SYS_CSRRSI, exu_pkg::CSR_MTVEC, 32'h0000_0018);
    csr_op(exu_pkg::SYS_CSRRCI, exu_pkg::CSR_MTVEC, 32'h0000_0003);
    csr_op(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MTVEC, 32'd0);

    // Trap entry and return.
    csr_op(exu_pkg::SYS_CSRRW, exu_pkg::CSR_MTVEC, 32'h0000_0100);
    sys_op(exu_pkg::SYS_ECALL);
    csr_op(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MEPC, 32'd0);
    csr_op(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MCAUSE, 32'd0);
    csr_op(exu_pkg::SYS_CSRRW, exu_pkg::CSR_MSTATUS, 32'h0000_0008);
    sys_op(exu_pkg::SYS_MRET);
    csr_op(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MSTATUS, 32'd0);
    sys_op(exu_pkg::SYS_EBREAK);

    bp_en = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      random_alu();
    end
    bp_en = 1'b0;

    repeat (4) @(negedge clk);
    print_counts();
    if (mismatch_errs == 0 && proto_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- sources.f
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_csr_file.sv
rtl/exu_stage.sv
rtl/exu_data_mem.sv
rtl/exu_top.sv
tests/tb_exu_top.sv

//--- Bender.yml
package:
  name: exu

sources:
  - rtl/exu_pkg.sv
  - rtl/exu_alu.sv
  - rtl/exu_csr_file.sv
  - rtl/exu_stage.sv
  - rtl/exu_data_mem.sv
  - rtl/exu_top.sv
  - target: test
    files:
      - tests/tb_exu_top.sv
